// ==== verilog/torus_pkg.sv ====
package torus_pkg;

    // Router size.
    localparam int NUM_PORTS = 7;
    localparam int PORT_W = 3;

    // Torus geometry, equal in all three dimensions.
    localparam int TORUS_SIZE = 4;
    localparam int COORD_W = 2;

    // Flit layout.
    // Destination coordinates sit in the low six bits, X lowest.
    localparam int FLIT_W = 32;
    localparam int DST_X_POS = 0;
    localparam int DST_Y_POS = 2;
    localparam int DST_Z_POS = 4;

    // Source port tag and sequence count pass through the router untouched.
    localparam int SRC_POS = 6;
    localparam int SRC_W = 3;
    localparam int SEQ_POS = 9;
    localparam int SEQ_W = 23;

    // Port numbering.
    // Plus links first, then minus links, in X, Y, Z order.
    localparam logic [PORT_W-1:0] PORT_LOCAL = 3'd0;
    localparam logic [PORT_W-1:0] PORT_XPOS = 3'd1;
    localparam logic [PORT_W-1:0] PORT_YPOS = 3'd2;
    localparam logic [PORT_W-1:0] PORT_ZPOS = 3'd3;
    localparam logic [PORT_W-1:0] PORT_XNEG = 3'd4;
    localparam logic [PORT_W-1:0] PORT_YNEG = 3'd5;
    localparam logic [PORT_W-1:0] PORT_ZNEG = 3'd6;

    // Entries per input FIFO.
    localparam int FIFO_DEPTH = 4;

endpackage

// ==== verilog/input_fifo.sv ====
module input_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  logic [torus_pkg::FLIT_W-1:0] in_flit,
    output logic                         in_ready,
    output logic                         out_valid,
    output logic [torus_pkg::FLIT_W-1:0] out_flit,
    input  logic                         out_ready
);

    localparam int depth = torus_pkg::FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    logic [torus_pkg::FLIT_W-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic push;
    logic pop;

    // Pointer advance with wrap at the last entry.
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != cnt_w'(depth));
    assign out_valid = (count != '0);
    assign out_flit  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Write port.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // Pointers and fill count.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/route_comp.sv ====
module route_comp #(
    parameter int cur_x = 0,
    parameter int cur_y = 0,
    parameter int cur_z = 0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  logic [torus_pkg::FLIT_W-1:0]    in_flit,
    output logic                            in_ready,
    output logic                            rc_valid,
    output logic [torus_pkg::FLIT_W-1:0]    rc_flit,
    output logic [torus_pkg::PORT_W-1:0]    rc_port,
    input  logic [torus_pkg::NUM_PORTS-1:0] grant
);

    localparam int cw = torus_pkg::COORD_W;
    localparam int half = torus_pkg::TORUS_SIZE / 2;
    localparam logic [cw-1:0] here_x = cw'(cur_x);
    localparam logic [cw-1:0] here_y = cw'(cur_y);
    localparam logic [cw-1:0] here_z = cw'(cur_z);

    logic [cw-1:0] dst_x;
    logic [cw-1:0] dst_y;
    logic [cw-1:0] dst_z;
    logic [torus_pkg::PORT_W-1:0] route_port;
    logic take;

    // Shortest way around one ring. A tie at half the ring goes plus.
    function automatic logic go_plus(input logic [cw-1:0] cur, input logic [cw-1:0] dst);
        int diff;
        diff = int'(dst) - int'(cur);
        if (diff > 0) begin
            return diff <= half;
        end
        return -diff >= half;
    endfunction

    assign dst_x = in_flit[torus_pkg::DST_X_POS +: cw];
    assign dst_y = in_flit[torus_pkg::DST_Y_POS +: cw];
    assign dst_z = in_flit[torus_pkg::DST_Z_POS +: cw];

    // Dimension order X, then Y, then Z.
    always_comb begin
        if (dst_x != here_x) begin
            route_port = go_plus(here_x, dst_x) ? torus_pkg::PORT_XPOS : torus_pkg::PORT_XNEG;
        end else if (dst_y != here_y) begin
            route_port = go_plus(here_y, dst_y) ? torus_pkg::PORT_YPOS : torus_pkg::PORT_YNEG;
        end else if (dst_z != here_z) begin
            route_port = go_plus(here_z, dst_z) ? torus_pkg::PORT_ZPOS : torus_pkg::PORT_ZNEG;
        end else begin
            route_port = torus_pkg::PORT_LOCAL;
        end
    end

    // Free when empty, or when the held flit leaves this cycle.
    assign in_ready = !rc_valid || (|grant);
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rc_valid <= 1'b0;
        end else if (take) begin
            rc_valid <= 1'b1;
        end else if (|grant) begin
            rc_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rc_flit <= in_flit;
            rc_port <= route_port;
        end
    end

endmodule

// ==== verilog/output_arbiter.sv ====
module output_arbiter #(
    parameter int port_id = 0
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [torus_pkg::NUM_PORTS-1:0]                     req_valid,
    input  logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::FLIT_W-1:0] req_flit,
    input  logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::PORT_W-1:0] req_port,
    output logic [torus_pkg::NUM_PORTS-1:0]                     grant,
    output logic                                                out_valid,
    output logic [torus_pkg::FLIT_W-1:0]                        out_flit,
    input  logic                                                out_ready
);

    localparam int n = torus_pkg::NUM_PORTS;
    localparam int pw = torus_pkg::PORT_W;
    localparam logic [pw-1:0] my_port = pw'(port_id);

    logic [n-1:0] req;
    logic [pw-1:0] prio;
    logic [pw-1:0] win;
    logic found;
    logic load_en;

    // Requests aimed at this output.
    always_comb begin
        for (int i = 0; i < n; i++) begin
            req[i] = req_valid[i] && (req_port[i] == my_port);
        end
    end

    // Search upward from the priority pointer, wrapping at the top.
    always_comb begin
        int idx;
        found = 1'b0;
        win   = '0;
        for (int k = 0; k < n; k++) begin
            idx = int'(prio) + k;
            if (idx >= n) begin
                idx = idx - n;
            end
            if (!found && req[idx]) begin
                found = 1'b1;
                win   = pw'(idx);
            end
        end
    end

    // Register is free when empty or being drained.
    assign load_en = !out_valid || out_ready;
    assign grant   = (found && load_en) ? ({{(n - 1){1'b0}}, 1'b1} << win) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            prio      <= '0;
        end else if (load_en) begin
            out_valid <= found;
            if (found) begin
                // Winner drops to lowest priority.
                prio <= (win == pw'(n - 1)) ? '0 : win + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && found) begin
            out_flit <= req_flit[win];
        end
    end

endmodule

// ==== verilog/torus_router.sv ====
module torus_router #(
    parameter int cur_x = 0,
    parameter int cur_y = 0,
    parameter int cur_z = 0
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [torus_pkg::NUM_PORTS-1:0]                        in_valid,
    input  logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::FLIT_W-1:0] in_flit,
    output logic [torus_pkg::NUM_PORTS-1:0]                        in_ready,
    output logic [torus_pkg::NUM_PORTS-1:0]                        out_valid,
    output logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::FLIT_W-1:0] out_flit,
    input  logic [torus_pkg::NUM_PORTS-1:0]                        out_ready
);

    localparam int n = torus_pkg::NUM_PORTS;

    // FIFO to route stage.
    logic [n-1:0] fifo_valid;
    logic [n-1:0][torus_pkg::FLIT_W-1:0] fifo_flit;
    logic [n-1:0] fifo_ready;

    // Route stage to arbiters.
    logic [n-1:0] rc_valid;
    logic [n-1:0][torus_pkg::FLIT_W-1:0] rc_flit;
    logic [n-1:0][torus_pkg::PORT_W-1:0] rc_port;

    // Indexed [output][input] as the arbiters drive them.
    logic [n-1:0][n-1:0] arb_grant;
    // Indexed [input][output] as the route stages take them.
    logic [n-1:0][n-1:0] rc_grant;

    genvar p;
    genvar q;

    generate
        for (p = 0; p < n; p++) begin : g_port
            input_fifo fifo_inst (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (in_valid[p]),
                .in_flit   (in_flit[p]),
                .in_ready  (in_ready[p]),
                .out_valid (fifo_valid[p]),
                .out_flit  (fifo_flit[p]),
                .out_ready (fifo_ready[p])
            );

            route_comp #(
                .cur_x (cur_x),
                .cur_y (cur_y),
                .cur_z (cur_z)
            ) rc_inst (
                .clk      (clk),
                .rst      (rst),
                .in_valid (fifo_valid[p]),
                .in_flit  (fifo_flit[p]),
                .in_ready (fifo_ready[p]),
                .rc_valid (rc_valid[p]),
                .rc_flit  (rc_flit[p]),
                .rc_port  (rc_port[p]),
                .grant    (rc_grant[p])
            );

            output_arbiter #(
                .port_id (p)
            ) arb_inst (
                .clk       (clk),
                .rst       (rst),
                .req_valid (rc_valid),
                .req_flit  (rc_flit),
                .req_port  (rc_port),
                .grant     (arb_grant[p]),
                .out_valid (out_valid[p]),
                .out_flit  (out_flit[p]),
                .out_ready (out_ready[p])
            );

            // Input p collects its own bit from every arbiter.
            for (q = 0; q < n; q++) begin : g_grant
                assign rc_grant[p][q] = arb_grant[q][p];
            end
        end
    endgenerate

endmodule

// ==== testbench/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset covers the first two rising edges.
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== testbench/torus_router_asserts.sv ====
module torus_router_asserts (
    input logic                                                      clk,
    input logic                                                      rst,
    input logic [torus_pkg::NUM_PORTS-1:0]                           out_valid,
    input logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::FLIT_W-1:0]    out_flit,
    input logic [torus_pkg::NUM_PORTS-1:0]                           out_ready,
    input logic [torus_pkg::NUM_PORTS-1:0]                           rc_valid,
    input logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::PORT_W-1:0]    rc_port,
    input logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::NUM_PORTS-1:0] arb_grant
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed checks, read by the testbench at the end of the run.
    int fail_count = 0;

    // Requests each arbiter can see, indexed [output][input].
    logic [torus_pkg::NUM_PORTS-1:0][torus_pkg::NUM_PORTS-1:0] req_mask;

    always_comb begin
        for (int o = 0; o < torus_pkg::NUM_PORTS; o++) begin
            for (int i = 0; i < torus_pkg::NUM_PORTS; i++) begin
                req_mask[o][i] = rc_valid[i] && (int'(rc_port[i]) == o);
            end
        end
    end

    // Outputs are empty in the cycle after any reset cycle.
    a_reset_idle: assert property (@(posedge clk) rst |=> out_valid == '0)
        else begin
            $error("output valid in the cycle after reset");
            fail_count++;
        end

    for (genvar p = 0; p < torus_pkg::NUM_PORTS; p++) begin : g_port
        // A stalled output keeps its flit.
        a_out_hold: assert property (@(posedge clk) disable iff (rst)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_flit[p]))
            else begin
                $error("output %0d dropped or changed a stalled flit", p);
                fail_count++;
            end

        // One requesting input at most wins an output per cycle.
        a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
            $onehot0(arb_grant[p]) && ((arb_grant[p] & ~req_mask[p]) == '0))
            else begin
                $error("arbiter %0d granted more than one input or an idle input", p);
                fail_count++;
            end
    end

endmodule

// ==== testbench/torus_router_tb.sv ====
module torus_router_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n = torus_pkg::NUM_PORTS;
    localparam int fw = torus_pkg::FLIT_W;
    localparam int pw = torus_pkg::PORT_W;
    localparam int cw = torus_pkg::COORD_W;
    localparam int node_x = 1;
    localparam int node_y = 2;
    localparam int node_z = 3;

    logic clk;
    logic rst;
    logic [n-1:0] in_valid;
    logic [n-1:0][fw-1:0] in_flit;
    logic [n-1:0] in_ready;
    logic [n-1:0] out_valid;
    logic [n-1:0][fw-1:0] out_flit;
    logic [n-1:0] out_ready;

    // Expected flits, one queue per source input and output, keyed src * 8 + output.
    logic [fw-1:0] exp_q [64][$];
    int seq_cnt [n] = '{default: 0};
    int pushed = 0;
    int received = 0;
    int value_errors = 0;
    int other_errors = 0;
    logic [31:0] lfsr = 32'hbd9c;
    logic fair_on = 1'b0;
    logic [pw-1:0] hot_port;
    logic [5:0] hot_dst;
    int recent [$];

    clock_gen clk_inst (
        .clk (clk),
        .rst (rst)
    );

    torus_router #(
        .cur_x (node_x),
        .cur_y (node_y),
        .cur_z (node_z)
    ) torus_router_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .out_ready (out_ready)
    );

    bind torus_router torus_router_asserts asserts_inst (
        .clk       (clk),
        .rst       (rst),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .out_ready (out_ready),
        .rc_valid  (rc_valid),
        .rc_port   (rc_port),
        .arb_grant (arb_grant)
    );

    // Taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [5:0] make_dst(input int x, input int y, input int z);
        return {cw'(z), cw'(y), cw'(x)};
    endfunction

    // Reference routing. Forward distance around each ring, X then Y then Z,
    // plus when the forward way is no longer than half the ring.
    function automatic logic [pw-1:0] expected_port(input logic [fw-1:0] flit);
        int here [3];
        int fwd;
        here = '{node_x, node_y, node_z};
        for (int d = 0; d < 3; d++) begin
            fwd = int'(flit[torus_pkg::DST_X_POS + d * cw +: cw]) - here[d];
            fwd = (fwd + torus_pkg::TORUS_SIZE) % torus_pkg::TORUS_SIZE;
            if (fwd != 0) begin
                if (fwd <= torus_pkg::TORUS_SIZE / 2) begin
                    return torus_pkg::PORT_XPOS + pw'(d);
                end
                return torus_pkg::PORT_XNEG + pw'(d);
            end
        end
        return torus_pkg::PORT_LOCAL;
    endfunction

    task automatic compare_flit(input int idx, input logic [fw-1:0] exp, input logic [fw-1:0] got);
        if (got !== exp) begin
            value_errors++;
            $display("** Error out_flit[%0d]: expected %h, got %h", idx, exp, got);
        end
    endtask

    task automatic compare_port(input int idx, input logic [pw-1:0] exp, input logic [pw-1:0] got);
        if (got !== exp) begin
            value_errors++;
            $display("** Error out_port[%0d]: expected %h, got %h", idx, exp, got);
        end
    endtask

    task automatic compare_mask(input string name, input logic [n-1:0] exp, input logic [n-1:0] got);
        if (got !== exp) begin
            value_errors++;
            $display("** Error %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic finish_run();
        int asserts_failed;
        asserts_failed = torus_router_inst.asserts_inst.fail_count;
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, asserts_failed);
        if (value_errors + other_errors + asserts_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        other_errors++;
        $display("Timed out waiting for %s", what);
        finish_run();
    endtask

    // Drive one flit on input p and record where it should leave.
    task automatic present_flit(input int p, input logic [5:0] dst);
        logic [fw-1:0] flit;
        flit = '0;
        flit[torus_pkg::DST_X_POS +: cw] = dst[1:0];
        flit[torus_pkg::DST_Y_POS +: cw] = dst[3:2];
        flit[torus_pkg::DST_Z_POS +: cw] = dst[5:4];
        flit[torus_pkg::SRC_POS +: torus_pkg::SRC_W] = torus_pkg::SRC_W'(p);
        flit[torus_pkg::SEQ_POS +: torus_pkg::SEQ_W] = torus_pkg::SEQ_W'(seq_cnt[p]);
        seq_cnt[p]++;
        in_valid[p] <= 1'b1;
        in_flit[p]  <= flit;
        exp_q[p * 8 + int'(expected_port(flit))].push_back(flit);
        pushed++;
    endtask

    task automatic wait_drained();
        int guard;
        guard = 0;
        while (received != pushed) begin
            @(posedge clk);
            guard++;
            if (guard > 2000) begin
                report_timeout("all flits to leave the router");
            end
        end
    endtask

    task automatic send_single(input int p, input logic [5:0] dst);
        int guard;
        guard = 0;
        present_flit(p, dst);
        do begin
            @(posedge clk);
            guard++;
        end while (!in_ready[p] && guard < 50);
        in_valid[p] <= 1'b0;
        if (guard >= 50) begin
            report_timeout("a single flit to be accepted");
        end
        wait_drained();
    endtask

    // Streams on all inputs. Random gaps, destinations and back-pressure,
    // or back-to-back flits to the hotspot destination.
    task automatic run_traffic(input int per_port, input logic hotspot);
        logic [n-1:0] busy;
        int sent [n];
        int done_cnt;
        int guard;
        logic [31:0] r;
        busy = '0;
        done_cnt = 0;
        guard = 0;
        sent = '{default: 0};
        while (done_cnt < per_port * n) begin
            @(posedge clk);
            guard++;
            if (guard > 20000) begin
                report_timeout("input handshakes");
            end
            for (int p = 0; p < n; p++) begin
                if (busy[p] && in_ready[p]) begin
                    busy[p] = 1'b0;
                    done_cnt++;
                end
                draw_bits(1, r);
                if (!busy[p] && sent[p] < per_port && (hotspot || r[0])) begin
                    draw_bits(6, r);
                    present_flit(p, hotspot ? hot_dst : r[5:0]);
                    sent[p]++;
                    busy[p] = 1'b1;
                end else if (!busy[p]) begin
                    in_valid[p] <= 1'b0;
                end
            end
            if (!hotspot) begin
                draw_bits(n, r);
                out_ready <= r[n-1:0];
            end
        end
        out_ready <= '1;
    endtask

    // Scoreboard. Checks every output transfer against the queue of its pair.
    always @(posedge clk) begin : monitor
        logic [fw-1:0] got;
        int src;
        if (!rst) begin
            for (int p = 0; p < n; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    got = out_flit[p];
                    src = int'(got[torus_pkg::SRC_POS +: torus_pkg::SRC_W]);
                    received++;
                    compare_port(p, expected_port(got), pw'(p));
                    if (exp_q[src * 8 + p].size() == 0) begin
                        other_errors++;
                        $display("Unexpected flit %h on output %0d", got, p);
                    end else begin
                        compare_flit(p, exp_q[src * 8 + p].pop_front(), got);
                    end
                    if (fair_on && pw'(p) == hot_port) begin
                        foreach (recent[i]) begin
                            if (recent[i] == src) begin
                                other_errors++;
                                $display("Input %0d won output %0d twice in seven deliveries",
                                         src, p);
                            end
                        end
                        recent.push_back(src);
                        if (recent.size() > n - 1) begin
                            void'(recent.pop_front());
                        end
                    end
                end
            end
        end
    end

    initial begin : main
        int guard;
        in_valid = '0;
        in_flit = '0;
        out_ready = '1;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
            if (guard > 20) begin
                report_timeout("reset release");
            end
        end while (rst);
        @(posedge clk);
        compare_mask("out_valid", '0, out_valid);
        compare_mask("in_ready", '1, in_ready);

        // One dimension differs at a time.
        send_single(0, make_dst(2, 2, 3));
        send_single(0, make_dst(0, 2, 3));
        send_single(0, make_dst(1, 3, 3));
        send_single(0, make_dst(1, 1, 3));
        send_single(0, make_dst(1, 2, 0));
        send_single(0, make_dst(1, 2, 2));

        // Ties at half the ring, own node, and X taken before Y and Z.
        send_single(0, make_dst(3, 2, 3));
        send_single(4, make_dst(1, 0, 3));
        send_single(5, make_dst(1, 2, 1));
        send_single(0, make_dst(1, 2, 3));
        send_single(2, make_dst(3, 0, 0));

        run_traffic(40, 1'b0);
        wait_drained();

        // Every input aims at Z minus.
        hot_dst = make_dst(1, 2, 2);
        hot_port = expected_port(fw'(hot_dst));
        recent.delete();
        fair_on = 1'b1;
        run_traffic(12, 1'b1);
        wait_drained();
        fair_on = 1'b0;

        for (int k = 0; k < 64; k++) begin
            if (exp_q[k].size() != 0) begin
                other_errors++;
                $display("%0d flits from input %0d never left output %0d",
                         exp_q[k].size(), k / 8, k % 8);
            end
        end
        finish_run();
    end

endmodule

// ==== torus_router.f ====
verilog/torus_pkg.sv
verilog/input_fifo.sv
verilog/route_comp.sv
verilog/output_arbiter.sv
verilog/torus_router.sv
testbench/clock_gen.sv
testbench/torus_router_asserts.sv
testbench/torus_router_tb.sv

// ==== Bender.yml ====
package:
  name: torus_router

sources:
  - verilog/torus_pkg.sv
  - verilog/input_fifo.sv
  - verilog/route_comp.sv
  - verilog/output_arbiter.sv
  - verilog/torus_router.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/torus_router_asserts.sv
      - testbench/torus_router_tb.sv
